// File: project.f
+incdir+include
logic/wiring_pkg.sv
logic/tap_decoder.sv
logic/line_decoder.sv
logic/tap_encoder.sv
logic/user_logic.sv
testbench/user_logic_properties.sv
testbench/user_logic_tb.sv

// File: Bender.yml
package:
  name: wiring_engine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/wiring_pkg.sv
      - logic/tap_decoder.sv
      - logic/line_decoder.sv
      - logic/tap_encoder.sv
      - logic/user_logic.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/user_logic_properties.sv
      - testbench/user_logic_tb.sv

// File: testbench/user_logic_tb.sv
`timescale 1ns/1ps

`include "wiring_settings.svh"

module user_logic_tb
    import wiring_pkg::*;
();

    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_LINES   = 200;
    localparam int CHECK_INTERVAL = 20;
    localparam int REPORT_BITS    = $bits(result_report_t);
    localparam logic [31:0] SEED  = 32'd35938;

    // Worst case per random line is 15 cells, 15 ignored bytes and a newline
    localparam int MAX_BYTES   = RANDOM_LINES * 32 + 100;
    localparam int MAX_READS   = RANDOM_LINES / CHECK_INTERVAL + 20;
    localparam int CYCLE_LIMIT = MAX_BYTES * 12 + MAX_READS * 25 + 2000;

    logic tck = 1'b0;
    logic tdi;
    logic test_logic_reset;
    logic run_test_idle;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;

    // Reference model state
    wiring_t     model_pending;
    int          model_cells;
    logic        model_eof;
    result_t     model_sum;
    logic [31:0] rng_state;
    int          cycle_count = 0;

    user_logic user_logic_i (
        .tck(tck),
        .tdi(tdi),
        .test_logic_reset(test_logic_reset),
        .run_test_idle(run_test_idle),
        .ir_is_user(ir_is_user),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .tdo(tdo)
    );

    always #4 tck = ~tck;

    always @(posedge tck) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "Run aborted after timeout");
        end
    end

    // Watch the bound checker
    always @(posedge tck) begin
        if (user_logic_i.user_logic_properties_i.failure_count != 0) begin
            $display("A bound assertion on the DUT failed");
            $display("Verification failed");
            $fatal(1, "Run aborted after assertion failure");
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Model update for one byte the DUT accepts
    task automatic apply_model(input byte_t b);
        if (!model_eof) begin
            if (b == `WIRING_CELL_ON_BYTE || b == `WIRING_CELL_OFF_BYTE) begin
                model_pending = {model_pending[`WIRING_WIDTH-2:0],
                                 (b == `WIRING_CELL_ON_BYTE) ? 1'b1 : 1'b0};
                model_cells++;
            end else if (b == `WIRING_NEWLINE_BYTE) begin
                model_sum     = model_sum + result_t'(model_pending);
                model_pending = '0;
                model_cells   = 0;
            end else if (b == `WIRING_EOF_BYTE) begin
                if (model_cells > 0) begin
                    model_sum = model_sum + result_t'(model_pending);
                end
                model_pending = '0;
                model_cells   = 0;
                model_eof     = 1'b1;
            end
        end
    endtask

    task automatic clear_model();
        model_pending = '0;
        model_cells   = 0;
        model_eof     = 1'b0;
        model_sum     = '0;
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge tck);
        test_logic_reset <= 1'b1;
        shift_dr         <= 1'b0;
        capture_dr       <= 1'b0;
        update_dr        <= 1'b0;
        repeat (cycles) @(posedge tck);
        test_logic_reset <= 1'b0;
        clear_model();
    endtask

    // LSB first, one bit per rising edge
    task automatic shift_bits(input logic [15:0] value, input int count, input logic user);
        for (int i = 0; i < count; i++) begin
            @(posedge tck);
            ir_is_user <= user;
            shift_dr   <= 1'b1;
            tdi        <= value[i];
        end
    endtask

    task automatic pulse_update(input logic user);
        @(posedge tck);
        shift_dr   <= 1'b0;
        tdi        <= 1'b0;
        ir_is_user <= user;
        update_dr  <= 1'b1;
        @(posedge tck);
        update_dr  <= 1'b0;
    endtask

    task automatic send_byte(input byte_t b, input logic user);
        shift_bits({8'h00, b}, 8, user);
        pulse_update(user);
    endtask

    task automatic send_char(input byte_t b);
        send_byte(b, 1'b1);
        apply_model(b);
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_char(byte_t'(text[i]));
        end
    endtask

    task automatic read_report(output result_report_t report);
        logic [REPORT_BITS-1:0] bits;
        // Let the last byte reach the sum before capture
        repeat (3) @(posedge tck);
        ir_is_user <= 1'b1;
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        for (int i = 0; i < REPORT_BITS; i++) begin
            @(negedge tck);
            bits[i] = tdo;
            @(posedge tck);
        end
        shift_dr <= 1'b0;
        report = result_report_t'(bits);
    endtask

    task automatic check_report(input string label);
        result_report_t report;
        read_report(report);
        check_equal(32'(report.sum), 32'(model_sum), {label, " sum"});
        check_equal(32'(report.done), 32'(model_eof), {label, " done"});
    endtask

    initial begin
        int cell_count;

        tdi              <= 1'b0;
        test_logic_reset <= 1'b1;
        run_test_idle    <= 1'b0;
        ir_is_user       <= 1'b1;
        capture_dr       <= 1'b0;
        shift_dr         <= 1'b0;
        update_dr        <= 1'b0;
        rng_state = SEED;
        clear_model();

        apply_reset(RESET_CYCLES);
        check_report("reset state");

        // 0101 gives five
        send_text(".#.#\n");
        check_report("single line");

        for (int line_idx = 0; line_idx < RANDOM_LINES; line_idx++) begin
            rng_state  = next_random(rng_state);
            cell_count = int'(rng_state[3:0]);
            for (int c = 0; c < cell_count; c++) begin
                rng_state = next_random(rng_state);
                // Space or carriage return now and then
                if (rng_state[10:8] == 3'd0) begin
                    send_char(rng_state[11] ? 8'h20 : 8'h0D);
                end
                send_char(rng_state[0] ? `WIRING_CELL_ON_BYTE : `WIRING_CELL_OFF_BYTE);
            end
            send_char(`WIRING_NEWLINE_BYTE);
            if ((line_idx + 1) % CHECK_INTERVAL == 0) begin
                check_report("random text");
            end
        end

        // Non-user traffic must not reach the parser
        send_char(`WIRING_CELL_ON_BYTE);
        send_byte(`WIRING_CELL_ON_BYTE, 1'b0);
        send_byte(`WIRING_NEWLINE_BYTE, 1'b0);
        // Bare user update delivers the last user byte again
        pulse_update(1'b1);
        apply_model(`WIRING_CELL_ON_BYTE);
        // Four junk bits first, then the byte that should arrive
        shift_bits({4'h0, `WIRING_CELL_OFF_BYTE, 4'b1011}, 12, 1'b1);
        pulse_update(1'b1);
        apply_model(`WIRING_CELL_OFF_BYTE);
        send_char(`WIRING_NEWLINE_BYTE);
        check_report("non-user and long shift");

        send_text("#..##.#");
        send_char(`WIRING_EOF_BYTE);
        check_report("end of file");
        send_text("###\n.#\n#");
        check_report("after end of file");

        apply_reset(RESET_CYCLES);
        check_report("after reset");
        send_text("##.");
        apply_reset(3);
        send_text("#.\n");
        check_report("line after reset");

        // One more edge so the checker has seen the last cycle
        @(posedge tck);
        if (user_logic_i.user_logic_properties_i.failure_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("A bound assertion on the DUT failed");
            $display("Verification failed");
            $fatal(1, "Run aborted after assertion failure");
        end
    end

endmodule

// File: testbench/user_logic_properties.sv
`timescale 1ns/1ps

module user_logic_properties
    import wiring_pkg::*;
(
    input wire                 tck,
    input wire                 test_logic_reset,
    input wire                 ir_is_user,
    input wire                 update_dr,
    input wire                 inbound_valid,
    input wire wiring_word_t   wiring,
    input wire result_report_t report,
    input wire                 tdo
);

    // Count of failed assertions
    int failure_count = 0;

    // Byte strobe only after a user update
    assert property (@(posedge tck) disable iff (test_logic_reset)
        inbound_valid |-> $past(update_dr && ir_is_user))
    else begin
        failure_count++;
        $error("inbound_valid without a user update one cycle before");
    end

    assert property (@(posedge tck) disable iff (test_logic_reset)
        wiring.valid |-> $past(inbound_valid))
    else begin
        failure_count++;
        $error("wiring word without a byte strobe one cycle before");
    end

    // Sticky done
    assert property (@(posedge tck) disable iff (test_logic_reset)
        report.done |=> report.done)
    else begin
        failure_count++;
        $error("done fell without reset");
    end

    assert property (@(posedge tck) test_logic_reset |=> !tdo)
    else begin
        failure_count++;
        $error("tdo high during reset");
    end

endmodule

bind user_logic user_logic_properties user_logic_properties_i (
    .tck(tck),
    .test_logic_reset(test_logic_reset),
    .ir_is_user(ir_is_user),
    .update_dr(update_dr),
    .inbound_valid(inbound_valid),
    .wiring(wiring),
    .report(report),
    .tdo(tdo)
);

// File: logic/user_logic.sv
`timescale 1ns/1ps
`default_nettype none

module user_logic
    import wiring_pkg::*;
(
    input  wire  tck,
    input  wire  tdi,
    input  wire  test_logic_reset,
    // Part of the TAP state set, not needed by this engine
    input  wire  run_test_idle,
    input  wire  ir_is_user,
    input  wire  capture_dr,
    input  wire  shift_dr,
    input  wire  update_dr,
    output logic tdo
);

    logic           inbound_valid;
    byte_t          inbound_byte;
    wiring_word_t   wiring;
    logic           end_of_file;
    result_report_t report;

    // Host bytes in
    tap_decoder #(
        .payload_t(byte_t)
    ) tap_decoder_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .tdi(tdi),
        .ir_is_user(ir_is_user),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .valid(inbound_valid),
        .data(inbound_byte)
    );

    line_decoder line_decoder_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .inbound_valid(inbound_valid),
        .inbound_byte(inbound_byte),
        .wiring(wiring),
        .end_of_file(end_of_file)
    );

    // Sum wraps naturally at the result width
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            report <= '0;
        end else begin
            report.done <= end_of_file;
            if (wiring.valid) begin
                report.sum <= report.sum + result_t'(wiring.data);
            end
        end
    end

    // Report out to the host
    tap_encoder #(
        .payload_t(result_report_t)
    ) tap_encoder_i (
        .tck(tck),
        .test_logic_reset(test_logic_reset),
        .ir_is_user(ir_is_user),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .report(report),
        .tdo(tdo)
    );

endmodule

`default_nettype wire

// File: logic/tap_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_encoder
    import wiring_pkg::*;
#(
    parameter type payload_t = result_report_t
) (
    input  wire           tck,
    input  wire           test_logic_reset,
    input  wire           ir_is_user,
    input  wire           capture_dr,
    input  wire           shift_dr,
    input  wire payload_t report,
    output logic          tdo
);

    localparam int PAYLOAD_WIDTH = $bits(payload_t);

    logic [PAYLOAD_WIDTH-1:0] shift_q;
    logic                     user_capture;
    logic                     user_shift;

    assign user_capture = capture_dr && ir_is_user;
    assign user_shift   = shift_dr && ir_is_user;

    // Capture takes the report of the same cycle
    // Shifting drains LSB first and refills the top with zeros
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            shift_q <= '0;
        end else if (user_capture) begin
            shift_q <= PAYLOAD_WIDTH'(report);
        end else if (user_shift) begin
            shift_q <= {1'b0, shift_q[PAYLOAD_WIDTH-1:1]};
        end
    end

    assign tdo = shift_q[0];

endmodule

`default_nettype wire

// File: logic/line_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "wiring_settings.svh"

module line_decoder
    import wiring_pkg::*;
(
    input  wire          tck,
    input  wire          test_logic_reset,
    input  wire          inbound_valid,
    input  wire byte_t   inbound_byte,
    output wiring_word_t wiring,
    output logic         end_of_file
);

    // Byte classes
    logic is_cell_on;
    logic is_cell_off;
    logic is_cell;
    logic is_newline;
    logic is_eof;

    // Bytes only count until end of file
    logic accept;

    // Line being assembled
    wiring_t pending_value;
    logic    pending_any;

    // Word emission for this byte
    logic emit;
    logic emit_eol;

    // Registered output fields
    logic    word_valid;
    logic    word_eol;
    wiring_t word_data;

    assign is_cell_on  = inbound_byte == `WIRING_CELL_ON_BYTE;
    assign is_cell_off = inbound_byte == `WIRING_CELL_OFF_BYTE;
    assign is_cell     = is_cell_on || is_cell_off;
    assign is_newline  = inbound_byte == `WIRING_NEWLINE_BYTE;
    assign is_eof      = inbound_byte == `WIRING_EOF_BYTE;

    assign accept = inbound_valid && !end_of_file;

    // Newline always emits, even an empty line
    // End of file only when a cell is waiting
    assign emit     = accept && (is_newline || (is_eof && pending_any));
    assign emit_eol = accept && is_newline;

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            pending_value <= '0;
            pending_any   <= 1'b0;
        end else if (accept) begin
            if (is_cell) begin
                // Oldest cell falls off the top past the line width
                pending_value <= {pending_value[`WIRING_WIDTH-2:0], is_cell_on};
                pending_any   <= 1'b1;
            end else if (is_newline || is_eof) begin
                pending_value <= '0;
                pending_any   <= 1'b0;
            end
        end
    end

    // Sticky until reset
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            end_of_file <= 1'b0;
        end else if (accept && is_eof) begin
            end_of_file <= 1'b1;
        end
    end

    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            word_valid <= 1'b0;
            word_eol   <= 1'b0;
        end else begin
            word_valid <= emit;
            word_eol   <= emit_eol;
        end
    end

    // Data only meaningful with the valid bit
    always_ff @(posedge tck) begin
        if (emit) begin
            word_data <= pending_value;
        end
    end

    assign wiring = '{valid: word_valid, end_of_line: word_eol, data: word_data};

endmodule

`default_nettype wire

// File: logic/tap_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tap_decoder
    import wiring_pkg::*;
#(
    parameter type payload_t = byte_t
) (
    input  wire      tck,
    input  wire      test_logic_reset,
    input  wire      tdi,
    input  wire      ir_is_user,
    input  wire      shift_dr,
    input  wire      update_dr,
    output logic     valid,
    output payload_t data
);

    localparam int PAYLOAD_WIDTH = $bits(payload_t);

    logic [PAYLOAD_WIDTH-1:0] shift_q;
    logic                     user_shift;
    logic                     user_update;

    assign user_shift  = shift_dr && ir_is_user;
    assign user_update = update_dr && ir_is_user;

    // LSB first on the wire, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (user_shift) begin
            shift_q <= {tdi, shift_q[PAYLOAD_WIDTH-1:1]};
        end
    end

    // Payload copy for the downstream logic
    always_ff @(posedge tck) begin
        if (user_update) begin
            data <= payload_t'(shift_q);
        end
    end

    // One-cycle strobe after each user update
    always_ff @(posedge tck) begin
        if (test_logic_reset) begin
            valid <= 1'b0;
        end else begin
            valid <= user_update;
        end
    end

endmodule

`default_nettype wire

// File: logic/wiring_pkg.sv
package wiring_pkg;

`include "wiring_settings.svh"

    // One inbound ASCII character
    typedef logic [7:0] byte_t;

    // Value of one text line, first cell most significant
    typedef logic [`WIRING_WIDTH-1:0] wiring_t;

    // Running sum
    typedef logic [`RESULT_WIDTH-1:0] result_t;

    // Parser output, valid for a single cycle
    typedef struct packed {
        logic    valid;
        logic    end_of_line;
        wiring_t data;
    } wiring_word_t;

    // Report read back by the host, done in the top bit
    typedef struct packed {
        logic    done;
        result_t sum;
    } result_report_t;

endpackage

// File: include/wiring_settings.svh
`ifndef WIRING_SETTINGS_SVH
`define WIRING_SETTINGS_SVH

// Widest line the parser keeps, in cells
`define WIRING_WIDTH 12

// Running sum wraps at this width
`define RESULT_WIDTH 16

// Line terminator
`define WIRING_NEWLINE_BYTE 8'h0A

// Hash character is a one cell
`define WIRING_CELL_ON_BYTE 8'h23

// Dot character is a zero cell
`define WIRING_CELL_OFF_BYTE 8'h2E

// ASCII end of transmission marks end of input
`define WIRING_EOF_BYTE 8'h04

`endif
